/* run_sim.sh */
#!/bin/sh
# build and run the SPI master testbench with Verilator
# exit status 0 only when the run reports no errors

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_spi_master -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_spi_master)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* spi_bit_timer.sv */
/*
 * cycle and bit timer for the SPI master
 * FRQ_DIV must be even and >= 2, PRE_DLY >= 1, SPI_WIDTH 2..32
 * ticks are combinational decodes of the counters and the phase input,
 * they are only valid in the phase they belong to
 */
`timescale 1ns/1ps

module spi_bit_timer import spi_pkg::*; #(
    parameter int FRQ_DIV   = 4,
    parameter int PRE_DLY   = 3,
    parameter int SPI_WIDTH = 32
) (
    input  logic       p_in_clk,
    input  logic       p_in_rst,
    input  spi_state_t i_state,
    output logic       o_lead_end,
    output logic       o_half,
    output logic       o_bit_end,
    output logic       o_last_bit
);

    // counter must reach the longer of the two phases
    localparam int CNT_MAX = (PRE_DLY > FRQ_DIV) ? PRE_DLY : FRQ_DIV;
    localparam int CNT_W   = $clog2(CNT_MAX);
    localparam int BIT_W   = $clog2(SPI_WIDTH);

    logic [CNT_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;

    // ------------------------------------------------------------------
    // cycle counter
    // ------------------------------------------------------------------
    always_ff @(posedge p_in_clk) begin
        if (p_in_rst) begin
            cyc_cnt <= '0;
        end else begin
            case (i_state)
                S_LEAD: cyc_cnt <= o_lead_end ? '0 : cyc_cnt + 1'b1;
                // wraps once per bit
                S_XFER: cyc_cnt <= o_bit_end ? '0 : cyc_cnt + 1'b1;
                default: cyc_cnt <= '0;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // bit counter
    // ------------------------------------------------------------------
    always_ff @(posedge p_in_clk) begin
        if (p_in_rst) begin
            bit_cnt <= '0;
        end else if (i_state != S_XFER) begin
            bit_cnt <= '0;
        end else if (o_bit_end) begin
            // back to zero on the final bit end
            bit_cnt <= o_last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // ticks
    // ------------------------------------------------------------------
    assign o_lead_end = (i_state == S_LEAD) && (cyc_cnt == CNT_W'(PRE_DLY - 1));
    assign o_half     = (i_state == S_XFER) && (cyc_cnt == CNT_W'(FRQ_DIV / 2 - 1));
    assign o_bit_end  = (i_state == S_XFER) && (cyc_cnt == CNT_W'(FRQ_DIV - 1));
    assign o_last_bit = (i_state == S_XFER) && (bit_cnt == BIT_W'(SPI_WIDTH - 1));

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_lead_range: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        (i_state == S_LEAD) |-> (int'(cyc_cnt) < PRE_DLY));

    a_xfer_range: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        (i_state == S_XFER) |-> (int'(cyc_cnt) < FRQ_DIV));

    // rising and falling sclk edges must not collide
    a_half_vs_end: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        !(o_half && o_bit_end));

endmodule

/* spi_ctrl_fsm.sv */
/*
 * control FSM for the mode 3 SPI master
 * i_start is only looked at in idle and dropped in any other state
 * sclk and cs_n are registered
 * datapath strobes are combinational decodes of the timer ticks and the state
 * o_done is a single cycle pulse in the first cycle after cs_n rises
 */
`timescale 1ns/1ps

module spi_ctrl_fsm import spi_pkg::*; (
    input  logic       p_in_clk,
    input  logic       p_in_rst,
    input  logic       i_start,
    input  logic       i_lead_end,
    input  logic       i_half,
    input  logic       i_bit_end,
    input  logic       i_last_bit,
    output spi_state_t o_state,
    output logic       o_sclk,
    output logic       o_cs_n,
    output logic       o_load,
    output logic       o_sample,
    output logic       o_shift,
    output logic       o_finish,
    output logic       o_done
);

    spi_state_t state_q;
    logic       sclk_q;
    logic       cs_n_q;
    logic       done_q;

    // ------------------------------------------------------------------
    // state and pin levels
    // ------------------------------------------------------------------
    always_ff @(posedge p_in_clk) begin
        if (p_in_rst) begin
            state_q <= S_IDLE;
            sclk_q  <= 1'b1;
            cs_n_q  <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            // done only lives for one cycle
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    sclk_q <= 1'b1;
                    cs_n_q <= 1'b1;
                    if (i_start) begin
                        // select the slave and start the lead-in
                        cs_n_q  <= 1'b0;
                        state_q <= S_LEAD;
                    end
                end
                S_LEAD: begin
                    if (i_lead_end) begin
                        // first falling edge puts bit 0 in front of the slave
                        sclk_q  <= 1'b0;
                        state_q <= S_XFER;
                    end
                end
                S_XFER: begin
                    // rising edge mid bit
                    if (i_half) begin
                        sclk_q <= 1'b1;
                    end
                    if (i_bit_end) begin
                        if (i_last_bit) begin
                            // frame over and clock parks high
                            sclk_q  <= 1'b1;
                            cs_n_q  <= 1'b1;
                            done_q  <= 1'b1;
                            state_q <= S_IDLE;
                        end else begin
                            sclk_q <= 1'b0;
                        end
                    end
                end
                default: begin
                    // recovery from an illegal encoding
                    sclk_q  <= 1'b1;
                    cs_n_q  <= 1'b1;
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // datapath strobes
    // ------------------------------------------------------------------
    // tx word goes in on the same edge as the first falling sclk
    assign o_load   = i_lead_end && (state_q == S_LEAD);
    assign o_sample = i_half && (state_q == S_XFER);
    assign o_shift  = i_bit_end && !i_last_bit && (state_q == S_XFER);
    assign o_finish = i_bit_end && i_last_bit && (state_q == S_XFER);

    assign o_state = state_q;
    assign o_sclk  = sclk_q;
    assign o_cs_n  = cs_n_q;
    assign o_done  = done_q;

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // idle always means slave deselected and sclk parked high
    a_idle_levels: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        (state_q == S_IDLE) |-> (cs_n_q && sclk_q));

    // done is a single cycle pulse
    a_done_pulse: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        done_q |=> !done_q);

endmodule

/* spi_master_top.sv */
/*
 * single channel SPI master, mode 3, LSB first
 * FRQ_DIV even and >= 2, PRE_DLY >= 1, SPI_WIDTH 2..32
 * i_txd must be stable from i_start to the end of the lead-in
 * no back-pressure, the slave cannot stall a frame
 */
`timescale 1ns/1ps

module spi_master_top import spi_pkg::*; #(
    parameter int FRQ_DIV   = 4,
    parameter int PRE_DLY   = 3,
    parameter int SPI_WIDTH = 32
) (
    input  logic                 p_in_clk,
    input  logic                 p_in_rst,
    input  logic                 i_start,
    input  logic [SPI_WIDTH-1:0] i_txd,
    input  logic                 i_spi_miso,
    output spi_pins_t            o_spi,
    output logic [SPI_WIDTH-1:0] o_rxd,
    output logic                 o_done
);

    spi_state_t state;
    logic       lead_end;
    logic       half;
    logic       bit_end;
    logic       last_bit;
    logic       load;
    logic       sample;
    logic       shift;
    logic       finish;
    logic       sclk;
    logic       cs_n;
    logic       mosi;

    // ------------------------------------------------------------------
    // control, timing and datapath
    // ------------------------------------------------------------------
    spi_ctrl_fsm i_fsm (
        .p_in_clk   (p_in_clk),
        .p_in_rst   (p_in_rst),
        .i_start    (i_start),
        .i_lead_end (lead_end),
        .i_half     (half),
        .i_bit_end  (bit_end),
        .i_last_bit (last_bit),
        .o_state    (state),
        .o_sclk     (sclk),
        .o_cs_n     (cs_n),
        .o_load     (load),
        .o_sample   (sample),
        .o_shift    (shift),
        .o_finish   (finish),
        .o_done     (o_done)
    );

    spi_bit_timer #(
        .FRQ_DIV   (FRQ_DIV),
        .PRE_DLY   (PRE_DLY),
        .SPI_WIDTH (SPI_WIDTH)
    ) i_timer (
        .p_in_clk   (p_in_clk),
        .p_in_rst   (p_in_rst),
        .i_state    (state),
        .o_lead_end (lead_end),
        .o_half     (half),
        .o_bit_end  (bit_end),
        .o_last_bit (last_bit)
    );

    spi_shift_path #(
        .SPI_WIDTH (SPI_WIDTH)
    ) i_shift (
        .p_in_clk (p_in_clk),
        .p_in_rst (p_in_rst),
        .i_load   (load),
        .i_sample (sample),
        .i_shift  (shift),
        .i_finish (finish),
        .i_txd    (i_txd),
        .i_miso   (i_spi_miso),
        .o_mosi   (mosi),
        .o_rxd    (o_rxd)
    );

    // pin group out to the slave
    assign o_spi = '{sclk: sclk, cs_n: cs_n, mosi: mosi};

endmodule

/* spi_pkg.sv */
/*
 * shared types for the mode 3 SPI master
 * spi_pins_t carries only the outgoing pins, MISO stays a plain input
 * spi_state_t is also the phase input of the bit timer, so the
 * encodings below are relied on by both blocks
 */
package spi_pkg;

    // ------------------------------------------------------------------
    // outgoing pin group
    // ------------------------------------------------------------------
    typedef struct packed {
        // serial clock, idle high in mode 3
        logic sclk;
        // chip select, active low
        logic cs_n;
        // master out, LSB first
        logic mosi;
    } spi_pins_t;

    // ------------------------------------------------------------------
    // controller states
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_LEAD = 2'd1,
        S_XFER = 2'd2
    } spi_state_t;

endpackage

/* spi_shift_path.sv */
/*
 * shift datapath, LSB first in both directions
 * i_txd is captured on i_load only, it need not be held after that
 * o_rxd changes only on i_finish and holds the last frame's word
 * for MSB first order the bits are swapped outside this block
 */
`timescale 1ns/1ps

module spi_shift_path #(
    parameter int SPI_WIDTH = 32
) (
    input  logic                 p_in_clk,
    input  logic                 p_in_rst,
    input  logic                 i_load,
    input  logic                 i_sample,
    input  logic                 i_shift,
    input  logic                 i_finish,
    input  logic [SPI_WIDTH-1:0] i_txd,
    input  logic                 i_miso,
    output logic                 o_mosi,
    output logic [SPI_WIDTH-1:0] o_rxd
);

    logic [SPI_WIDTH-1:0] tx_sr;
    logic [SPI_WIDTH-1:0] rx_sr;
    logic [SPI_WIDTH-1:0] rxd_q;

    // ------------------------------------------------------------------
    // transmit side
    // ------------------------------------------------------------------
    always_ff @(posedge p_in_clk) begin
        if (p_in_rst) begin
            tx_sr <= '0;
        end else if (i_load) begin
            tx_sr <= i_txd;
        end else if (i_shift) begin
            // zero fill from the top
            tx_sr <= {1'b0, tx_sr[SPI_WIDTH-1:1]};
        end
    end

    // bit 0 is on the wire
    assign o_mosi = tx_sr[0];

    // ------------------------------------------------------------------
    // receive side
    // ------------------------------------------------------------------
    always_ff @(posedge p_in_clk) begin
        if (i_load) begin
            rx_sr <= '0;
        end else if (i_sample) begin
            // first bit in ends up at bit 0 after SPI_WIDTH samples
            rx_sr <= {i_miso, rx_sr[SPI_WIDTH-1:1]};
        end
    end

    // word latch, last sample was taken half a bit earlier
    always_ff @(posedge p_in_clk) begin
        if (p_in_rst) begin
            rxd_q <= '0;
        end else if (i_finish) begin
            rxd_q <= rx_sr;
        end
    end

    assign o_rxd = rxd_q;

    a_load_vs_shift: assert property (@(posedge p_in_clk) disable iff (p_in_rst)
        !(i_load && i_shift));

endmodule

/* tb_spi_master.sv */
/*
 * testbench for the mode 3 SPI master with a behavioural slave
 * FRQ_DIV 4, PRE_DLY 3, SPI_WIDTH 32
 * inputs change on the falling clock edge, outputs are sampled there too
 */
`timescale 1ns/1ps

module tb_spi_master import spi_pkg::*; ();

    localparam int FRQ_DIV    = 4;
    localparam int PRE_DLY    = 3;
    localparam int W          = 32;
    // cs_n low time of one frame in clock cycles
    localparam int FRAME_LEN  = PRE_DLY + W * FRQ_DIV;
    localparam int DONE_LIMIT = FRAME_LEN + 40;

    logic         p_in_clk  = 1'b0;
    logic         p_in_rst  = 1'b1;
    logic         start     = 1'b0;
    logic [W-1:0] txd       = '0;
    logic [W-1:0] miso_word = '0;
    logic         miso;
    spi_pins_t    spi;
    logic [W-1:0] rxd;
    logic         done;
    logic [W-1:0] slave_word;
    int           slave_rises;
    int           slave_frames;

    logic [W-1:0] exp_txd     = '0;
    logic [W-1:0] exp_miso    = '0;
    int           exp_frames  = 0;
    int           stim_errors = 0;
    int           mon_errors  = 0;
    int           seed        = 83290;
    int           low_cnt     = 0;
    logic         prev_cs_n   = 1'b1;

    always #4 p_in_clk = ~p_in_clk;

    spi_master_top #(
        .FRQ_DIV   (FRQ_DIV),
        .PRE_DLY   (PRE_DLY),
        .SPI_WIDTH (W)
    ) i_dut (
        .p_in_clk   (p_in_clk),
        .p_in_rst   (p_in_rst),
        .i_start    (start),
        .i_txd      (txd),
        .i_spi_miso (miso),
        .o_spi      (spi),
        .o_rxd      (rxd),
        .o_done     (done)
    );

    tb_spi_slave #(
        .SPI_WIDTH (W)
    ) i_slave (
        .i_spi       (spi),
        .i_miso_word (miso_word),
        .o_miso      (miso),
        .o_mosi_word (slave_word),
        .o_rise_cnt  (slave_rises),
        .o_frame_cnt (slave_frames)
    );

    // ------------------------------------------------------------------
    // pin monitor, reset is already applied at the first falling edge
    // ------------------------------------------------------------------
    always @(negedge p_in_clk) begin
        // slave deselected means clock parked high
        if (spi.cs_n) begin
            assert (spi.sclk == 1'b1) else begin
                mon_errors++;
                $display("FAIL idle_sclk expected 1 actual %b", spi.sclk);
            end
        end
        // done only in the first cycle after cs_n rises
        assert (done == (spi.cs_n && !prev_cs_n)) else begin
            mon_errors++;
            $display("FAIL done_pulse expected %b actual %b", spi.cs_n && !prev_cs_n, done);
        end
        if (spi.cs_n && !prev_cs_n) begin
            assert (low_cnt == FRAME_LEN) else begin
                mon_errors++;
                $display("FAIL frame_len expected %0d actual %0d", FRAME_LEN, low_cnt);
            end
            low_cnt = 0;
        end
        if (!spi.cs_n) begin
            low_cnt++;
        end
        prev_cs_n = spi.cs_n;
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    // one cycle strobe, txd held until the next frame
    task automatic start_frame(input logic [W-1:0] word, input logic [W-1:0] resp);
        exp_txd   = word;
        exp_miso  = resp;
        txd       = word;
        miso_word = resp;
        start     = 1'b1;
        exp_frames++;
        @(negedge p_in_clk);
        start = 1'b0;
    endtask

    // returns on the falling edge of the done cycle
    task automatic wait_done(input string name, input bit busy);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < DONE_LIMIT) begin
            @(negedge p_in_clk);
            n++;
            // stray strobes while the frame runs
            start = busy && (n == 1 || n == 40 || n == 97 || n == FRAME_LEN - 1);
            if (done) begin
                seen = 1'b1;
            end
        end
        start = 1'b0;
        if (!seen) begin
            stim_errors++;
            $display("%s: no done pulse within %0d cycles", name, DONE_LIMIT);
        end else begin
            assert (slave_word == exp_txd) else begin
                stim_errors++;
                $display("FAIL %s_tx expected %h actual %h", name, exp_txd, slave_word);
            end
            assert (rxd == exp_miso) else begin
                stim_errors++;
                $display("FAIL %s_rx expected %h actual %h", name, exp_miso, rxd);
            end
            assert (slave_rises == W) else begin
                stim_errors++;
                $display("FAIL %s_edges expected %0d actual %0d", name, W, slave_rises);
            end
            assert (slave_frames == exp_frames) else begin
                stim_errors++;
                $display("FAIL %s_frames expected %0d actual %0d",
                         name, exp_frames, slave_frames);
            end
        end
    endtask

    // no frame may start without a strobe
    task automatic watch_idle(input string name, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge p_in_clk);
            assert (spi.cs_n == 1'b1) else begin
                stim_errors++;
                $display("%s: chip select fell without a start strobe", name);
            end
        end
        assert (slave_frames == exp_frames) else begin
            stim_errors++;
            $display("FAIL %s_idle_frames expected %0d actual %0d",
                     name, exp_frames, slave_frames);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [W-1:0] word;
        logic [W-1:0] resp;
        int           k;

        repeat (8) @(negedge p_in_clk);
        p_in_rst = 1'b0;

        // levels straight after reset
        assert (spi.cs_n == 1'b1 && spi.sclk == 1'b1) else begin
            stim_errors++;
            $display("FAIL reset_pins expected 11 actual %b%b", spi.cs_n, spi.sclk);
        end
        assert (done == 1'b0 && rxd == '0) else begin
            stim_errors++;
            $display("FAIL reset_out expected 0 actual %b %h", done, rxd);
        end

        // fixed patterns
        start_frame(32'h0000_0000, 32'hffff_ffff);
        wait_done("zeros", 1'b0);
        watch_idle("zeros", 5);
        start_frame(32'hffff_ffff, 32'h0000_0000);
        wait_done("ones", 1'b0);
        watch_idle("ones", 5);
        start_frame(32'h0000_0001, 32'h8000_0001);
        wait_done("lsb", 1'b0);
        watch_idle("lsb", 5);

        // random words with short gaps
        for (k = 0; k < 6; k++) begin
            word = $random(seed);
            resp = $random(seed);
            start_frame(word, resp);
            wait_done("random", 1'b0);
            watch_idle("random", 2 + k);
        end

        // strobes while busy are dropped
        word = $random(seed);
        resp = $random(seed);
        start_frame(word, resp);
        wait_done("busy", 1'b1);
        watch_idle("busy", 20);

        // next start in the done cycle
        word = $random(seed);
        resp = $random(seed);
        start_frame(word, resp);
        for (k = 0; k < 4; k++) begin
            wait_done("chain", 1'b0);
            if (k < 3) begin
                word = $random(seed);
                resp = $random(seed);
                start_frame(word, resp);
            end
        end
        watch_idle("chain", 10);

        $display("errors: stimulus %0d, monitor %0d", stim_errors, mon_errors);
        if (stim_errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb_spi_slave.sv */
/*
 * behavioural mode 3 SPI slave, LSB first
 * captures MOSI on rising sclk and drives MISO after each falling sclk
 * the word and edge count of a frame are exposed when cs_n rises
 */
`timescale 1ns/1ps

module tb_spi_slave import spi_pkg::*; #(
    parameter int SPI_WIDTH = 32
) (
    input  spi_pins_t            i_spi,
    input  logic [SPI_WIDTH-1:0] i_miso_word,
    output logic                 o_miso,
    output logic [SPI_WIDTH-1:0] o_mosi_word,
    output int                   o_rise_cnt,
    output int                   o_frame_cnt
);

    logic                 sclk;
    logic                 cs_n;
    logic                 mosi;
    logic                 sclk_prev = 1'b1;
    logic                 cs_prev   = 1'b1;
    logic                 miso_q    = 1'b0;
    logic [SPI_WIDTH-1:0] cap_word  = '0;
    logic [SPI_WIDTH-1:0] word_q    = '0;
    logic [SPI_WIDTH-1:0] miso_bits = '0;
    logic [SPI_WIDTH-1:0] bit_mask  = '0;
    int                   rise_cnt  = 0;
    int                   fall_cnt  = 0;
    int                   rises_q   = 0;
    int                   frames_q  = 0;

    assign sclk = i_spi.sclk;
    assign cs_n = i_spi.cs_n;
    assign mosi = i_spi.mosi;

    // ------------------------------------------------------------------
    // pin edges, told apart by the previous levels
    // ------------------------------------------------------------------
    always @(posedge sclk or negedge sclk or posedge cs_n or negedge cs_n) begin
        // new frame
        if (cs_n === 1'b0 && cs_prev === 1'b1) begin
            cap_word = '0;
            rise_cnt = 0;
            fall_cnt = 0;
        end
        // falling sclk, next bit of the preset word on MISO
        if (cs_n === 1'b0 && sclk === 1'b0 && sclk_prev === 1'b1) begin
            miso_bits = i_miso_word >> fall_cnt;
            miso_q    = miso_bits[0];
            fall_cnt++;
        end
        // rising sclk, MOSI into bit n
        if (cs_n === 1'b0 && sclk === 1'b1 && sclk_prev === 1'b0) begin
            bit_mask = SPI_WIDTH'(1) << rise_cnt;
            if (mosi === 1'b1) begin
                cap_word = cap_word | bit_mask;
            end
            rise_cnt++;
        end
        // end of frame
        if (cs_n === 1'b1 && cs_prev === 1'b0) begin
            word_q   = cap_word;
            rises_q  = rise_cnt;
            frames_q = frames_q + 1;
        end
        cs_prev   = cs_n;
        sclk_prev = sclk;
    end

    assign o_miso      = miso_q;
    assign o_mosi_word = word_q;
    assign o_rise_cnt  = rises_q;
    assign o_frame_cnt = frames_q;

endmodule

/* vlog.f */
spi_pkg.sv
spi_bit_timer.sv
spi_ctrl_fsm.sv
spi_shift_path.sv
spi_master_top.sv
tb_spi_slave.sv
tb_spi_master.sv
